//--- design/cacheAddrPkg.sv
package cacheAddrPkg;

    // Byte offset inside a 32-bit word
    localparam int byteOffBits = 2;

    // Word select inside a 16-word block
    localparam int wordOffBits = 4;

    // Set index of the direct-mapped cache
    localparam int indexBits = 4;
    localparam int numSets = 1 << indexBits;

    // Whatever is left of the address is tag
    localparam int tagBits = 32 - indexBits - wordOffBits - byteOffBits;

    typedef struct packed {
        logic [tagBits-1:0] tag;
        logic [indexBits-1:0] index;
        logic [wordOffBits-1:0] wordOff;
        logic [byteOffBits-1:0] byteOff;
    } addrFields_t;

    // Same 32 bits seen as a plain word or split into cache fields
    typedef union packed {
        logic [31:0] raw;
        addrFields_t f;
    } cacheAddr_u;

endpackage

//--- design/blockPkg.sv
package blockPkg;

    localparam int wordBits = 32;
    localparam int wordsPerBlock = 16;
    localparam int blockBits = wordBits * wordsPerBlock;

    // One cache line with lane n holding word n of the block
    typedef logic [wordsPerBlock-1:0][wordBits-1:0] cacheBlock_t;

endpackage

//--- design/dataCache.sv
`timescale 1ns/1ps

module dataCache
    import cacheAddrPkg::*;
    import blockPkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                en,
    input  cacheAddr_u          addr,
    input  logic                rd,
    input  logic                wr,
    input  logic                ld,
    input  logic [wordBits-1:0] dataIn,
    input  cacheBlock_t         blkIn,
    output logic [wordBits-1:0] dataOut,
    output logic                hit,
    output logic                miss,
    output logic                evict,
    output cacheBlock_t         blkOut,
    output logic [31:0]         victimAddr
);

    // Line storage and tags
    cacheBlock_t        dataMem [numSets];
    logic [tagBits-1:0] tagMem  [numSets];

    // Per-set state bits
    logic [numSets-1:0] validBits;
    logic [numSets-1:0] dirtyBits;

    logic [indexBits-1:0]   idx;
    logic [wordOffBits-1:0] lane;
    logic                   tagMatch;
    logic                   access;
    logic                   writeHit;
    cacheAddr_u             victim;

    assign idx = addr.f.index;
    assign lane = addr.f.wordOff;

    assign access = en && (rd || wr);
    assign tagMatch = validBits[idx] && (tagMem[idx] == addr.f.tag);

    assign hit = access && tagMatch;
    assign miss = access && !tagMatch;

    // Only a dirty line under a different tag has to go back first
    assign evict = en && validBits[idx] && dirtyBits[idx] && !tagMatch;

    assign writeHit = en && wr && tagMatch && !ld;

    assign dataOut = (en && rd && tagMatch) ? dataMem[idx][lane] : '0;
    assign blkOut = dataMem[idx];

    // Stored line's address rebuilt from its tag and this set
    always_comb begin
        victim.f.tag = tagMem[idx];
        victim.f.index = idx;
        victim.f.wordOff = '0;
        victim.f.byteOff = '0;
    end

    assign victimAddr = victim.raw;

    always_ff @(posedge clk) begin
        if (en && ld) begin
            dataMem[idx] <= blkIn;
            tagMem[idx] <= addr.f.tag;
        end else if (writeHit) begin
            dataMem[idx][lane] <= dataIn;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            validBits <= '0;
            dirtyBits <= '0;
        end else begin
            if (en && ld) begin
                // Fresh fill is clean
                validBits[idx] <= 1'b1;
                dirtyBits[idx] <= 1'b0;
            end else if (writeHit) begin
                dirtyBits[idx] <= 1'b1;
            end
        end
    end

endmodule

//--- design/memController.sv
`timescale 1ns/1ps

module memController
    import blockPkg::*;
#(
    parameter int memLatency = 3,
    parameter int memLines = 64
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        cacheEvict,
    input  logic [31:0] evictAddr,
    input  cacheBlock_t mcDataOut,
    input  logic        cacheMiss,
    input  logic [31:0] missAddr,
    output logic        evictDone,
    output logic        mcDataValid,
    output cacheBlock_t mcDataIn
);

    localparam int blkOffBits = $clog2(blockBits / 8);
    localparam int lineBits = (memLines > 1) ? $clog2(memLines) : 1;
    localparam int cntBits = (memLatency > 1) ? $clog2(memLatency) : 1;
    localparam logic [cntBits-1:0] lastCnt = cntBits'(memLatency - 1);

    cacheBlock_t blockMem [memLines];

    logic [cntBits-1:0]  cnt;
    logic                evictArmed;
    logic                missArmed;
    logic                evictActive;
    logic                missActive;
    logic                lastCycle;
    logic [lineBits-1:0] evictLine;
    logic [lineBits-1:0] missLine;

    assign evictLine = evictAddr[blkOffBits +: lineBits];
    assign missLine = missAddr[blkOffBits +: lineBits];

    // A request counts only once per rising level
    assign evictActive = cacheEvict && evictArmed;
    assign missActive = cacheMiss && missArmed && !evictActive;
    assign lastCycle = (cnt == lastCnt);

    // Fill data is shown in the last latency cycle
    assign mcDataValid = missActive && lastCycle;
    assign mcDataIn = mcDataValid ? blockMem[missLine] : '0;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cnt <= '0;
            evictArmed <= 1'b1;
            missArmed <= 1'b1;
            evictDone <= 1'b0;
            for (int i = 0; i < memLines; i++) begin
                blockMem[i] <= '0;
            end
        end else begin
            evictDone <= 1'b0;
            if (!cacheEvict) begin
                evictArmed <= 1'b1;
            end
            if (!cacheMiss) begin
                missArmed <= 1'b1;
            end

            if (evictActive || missActive) begin
                if (lastCycle) begin
                    cnt <= '0;
                    if (evictActive) begin
                        // Done is flagged the cycle after the write
                        blockMem[evictLine] <= mcDataOut;
                        evictDone <= 1'b1;
                        evictArmed <= 1'b0;
                    end else begin
                        missArmed <= 1'b0;
                    end
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end else begin
                cnt <= '0;
            end
        end
    end

endmodule

//--- design/memAccessCtrl.sv
`timescale 1ns/1ps

module memAccessCtrl
    import cacheAddrPkg::*;
    import blockPkg::*;
(
    input  logic                clk,
    input  logic                rst,

    // Pipeline request, held until dataValid
    input  logic                memRead,
    input  logic                memWrite,
    input  logic [31:0]         aluResult,
    input  logic [wordBits-1:0] read2Data,

    // Cache lookup results
    input  logic                hit,
    input  logic                miss,
    input  logic                evict,
    input  logic [wordBits-1:0] cacheDataOut,
    input  cacheBlock_t         victimBlk,
    input  logic [31:0]         victimAddr,

    // Backing memory responses
    input  logic                evictDone,
    input  logic                mcDataValid,
    input  cacheBlock_t         mcDataIn,

    // Cache controls
    output cacheAddr_u          cacheAddr,
    output logic                cacheEnable,
    output logic                cacheRead,
    output logic                cacheWrite,
    output logic                cacheLoad,
    output logic [wordBits-1:0] cacheDataIn,
    output cacheBlock_t         cacheBlkIn,

    // Backing memory requests
    output logic                cacheEvict,
    output logic                cacheMiss,
    output logic [31:0]         evictAddr,
    output logic [31:0]         missAddr,
    output cacheBlock_t         mcDataOut,

    // Back to the pipeline
    output logic [wordBits-1:0] memoryOut,
    output logic                dataValid,
    output logic                stall
);

    localparam logic [2:0] stIdle   = 3'd0;
    localparam logic [2:0] stLookup = 3'd1;
    localparam logic [2:0] stEvict  = 3'd2;
    localparam logic [2:0] stFill   = 3'd3;
    localparam logic [2:0] stRetry  = 3'd4;

    logic [2:0] state;
    logic [2:0] nextState;

    // Set while the pending operation is a store
    logic opWrite;

    // Request address aligned down to its block
    cacheAddr_u reqBlk;

    always_comb begin
        reqBlk.raw = aluResult;
        reqBlk.f.wordOff = '0;
        reqBlk.f.byteOff = '0;
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= stIdle;
            opWrite <= 1'b0;
        end else begin
            state <= nextState;
            // Loads win if both levels are up
            if (state == stIdle && (memRead || memWrite)) begin
                opWrite <= memWrite && !memRead;
            end
        end
    end

    always_comb begin
        nextState = state;
        cacheAddr = '0;
        cacheEnable = 1'b0;
        cacheRead = 1'b0;
        cacheWrite = 1'b0;
        cacheLoad = 1'b0;
        cacheDataIn = '0;
        cacheBlkIn = '0;
        cacheEvict = 1'b0;
        cacheMiss = 1'b0;
        evictAddr = '0;
        missAddr = '0;
        mcDataOut = '0;
        memoryOut = '0;
        dataValid = 1'b0;
        stall = 1'b0;

        case (state)
            stIdle: begin
                stall = memRead || memWrite;
                nextState = (memRead || memWrite) ? stLookup : stIdle;
            end
            stLookup: begin
                cacheAddr.raw = aluResult;
                cacheEnable = 1'b1;
                cacheRead = !opWrite;
                cacheWrite = opWrite;
                cacheDataIn = opWrite ? read2Data : '0;
                if (hit) begin
                    // Store lands at this edge, load data is already out
                    dataValid = 1'b1;
                    memoryOut = opWrite ? '0 : cacheDataOut;
                    nextState = stIdle;
                end else if (miss) begin
                    stall = 1'b1;
                    nextState = evict ? stEvict : stFill;
                end else begin
                    stall = 1'b1;
                end
            end
            stEvict: begin
                // Hold the address so the victim stays on the cache outputs
                cacheAddr.raw = aluResult;
                cacheEnable = 1'b1;
                cacheEvict = 1'b1;
                evictAddr = victimAddr;
                mcDataOut = victimBlk;
                stall = 1'b1;
                nextState = evictDone ? stFill : stEvict;
            end
            stFill: begin
                cacheAddr.raw = aluResult;
                cacheEnable = 1'b1;
                cacheMiss = 1'b1;
                missAddr = reqBlk.raw;
                cacheLoad = mcDataValid;
                cacheBlkIn = mcDataIn;
                stall = 1'b1;
                nextState = mcDataValid ? stRetry : stFill;
            end
            stRetry: begin
                // New line settles before the lookup is repeated
                stall = 1'b1;
                nextState = stLookup;
            end
            default: begin
                stall = 1'b1;
                nextState = stIdle;
            end
        endcase
    end

endmodule

//--- design/memStage.sv
`timescale 1ns/1ps

module memStage
    import cacheAddrPkg::*;
    import blockPkg::*;
#(
    parameter int memLatency = 3,
    parameter int memLines = 64
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        memRead,
    input  logic        memWrite,
    input  logic [31:0] aluResult,
    input  logic [31:0] read2Data,
    output logic [31:0] memoryOut,
    output logic        dataValid,
    output logic        stall
);

    // Controller and cache
    cacheAddr_u          cacheAddr;
    logic                cacheEnable;
    logic                cacheRead;
    logic                cacheWrite;
    logic                cacheLoad;
    logic [wordBits-1:0] cacheDataIn;
    cacheBlock_t         cacheBlkIn;
    logic                hit;
    logic                miss;
    logic                evict;
    logic [wordBits-1:0] cacheDataOut;
    cacheBlock_t         victimBlk;
    logic [31:0]         victimAddr;

    // Controller and backing memory
    logic                cacheEvict;
    logic                cacheMiss;
    logic [31:0]         evictAddr;
    logic [31:0]         missAddr;
    cacheBlock_t         mcDataOut;
    logic                evictDone;
    logic                mcDataValid;
    cacheBlock_t         mcDataIn;

    memAccessCtrl memAccessCtrl_i (
        .clk(clk), .rst(rst),
        .memRead(memRead), .memWrite(memWrite),
        .aluResult(aluResult), .read2Data(read2Data),
        .hit(hit), .miss(miss), .evict(evict),
        .cacheDataOut(cacheDataOut), .victimBlk(victimBlk), .victimAddr(victimAddr),
        .evictDone(evictDone), .mcDataValid(mcDataValid), .mcDataIn(mcDataIn),
        .cacheAddr(cacheAddr), .cacheEnable(cacheEnable),
        .cacheRead(cacheRead), .cacheWrite(cacheWrite), .cacheLoad(cacheLoad),
        .cacheDataIn(cacheDataIn), .cacheBlkIn(cacheBlkIn),
        .cacheEvict(cacheEvict), .cacheMiss(cacheMiss),
        .evictAddr(evictAddr), .missAddr(missAddr), .mcDataOut(mcDataOut),
        .memoryOut(memoryOut), .dataValid(dataValid), .stall(stall)
    );

    dataCache dataCache_i (
        .clk(clk), .rst(rst), .en(cacheEnable), .addr(cacheAddr),
        .rd(cacheRead), .wr(cacheWrite), .ld(cacheLoad),
        .dataIn(cacheDataIn), .blkIn(cacheBlkIn),
        .dataOut(cacheDataOut), .hit(hit), .miss(miss), .evict(evict),
        .blkOut(victimBlk), .victimAddr(victimAddr)
    );

    memController #(
        .memLatency(memLatency),
        .memLines(memLines)
    ) memController_i (
        .clk(clk), .rst(rst),
        .cacheEvict(cacheEvict), .evictAddr(evictAddr), .mcDataOut(mcDataOut),
        .cacheMiss(cacheMiss), .missAddr(missAddr),
        .evictDone(evictDone), .mcDataValid(mcDataValid), .mcDataIn(mcDataIn)
    );

endmodule

//--- verif/memStageTb.sv
`timescale 1ns/1ps

module memStageTb
    import cacheAddrPkg::*;
    import blockPkg::*;
();

    localparam int memLatency = 3;
    localparam int memLines = 64;
    localparam int halfPeriod = 2;
    localparam int resetCycles = 4;
    localparam int waitLimit = 64;
    localparam int refWords = memLines * wordsPerBlock;
    localparam int blockBytes = wordsPerBlock * (wordBits / 8);
    localparam logic [31:0] seed = 32'h7c64e30e;

    logic        clk;
    logic        rst;
    logic        memRead;
    logic        memWrite;
    logic [31:0] aluResult;
    logic [31:0] read2Data;
    logic [31:0] memoryOut;
    logic        dataValid;
    logic        stall;

    // Word image of the backing store
    logic [wordBits-1:0] refMem [refWords];

    // Line state the cache is expected to hold
    logic [numSets-1:0] modelValid;
    logic [numSets-1:0] modelDirty;
    logic [tagBits-1:0] modelTag [numSets];

    int errorCount;
    int timeoutCount;
    int pulseCount;
    int requestCount;
    bit timedOut;

    memStage #(
        .memLatency(memLatency),
        .memLines(memLines)
    ) memStage_i (
        .clk(clk), .rst(rst),
        .memRead(memRead), .memWrite(memWrite),
        .aluResult(aluResult), .read2Data(read2Data),
        .memoryOut(memoryOut), .dataValid(dataValid), .stall(stall)
    );

    always #halfPeriod clk = ~clk;

    // Protocol rules hold in every cycle
    always @(posedge clk) begin
        if (!rst) begin
            assert (!(stall && dataValid)) else begin
                errorCount++;
                $display("mismatch at %0t: dataValid high while stall is high", $time);
            end
            assert (dataValid || memoryOut == '0) else begin
                errorCount++;
                $display("mismatch at %0t: memoryOut %h without dataValid", $time, memoryOut);
            end
            // A pending request keeps stall up until its dataValid cycle
            assert (!(memRead || memWrite) || dataValid || stall) else begin
                errorCount++;
                $display("mismatch at %0t: request pending with stall low", $time);
            end
            if (dataValid) begin
                pulseCount++;
            end
        end
    end

    function automatic int wordIndex(input logic [31:0] addr);
        return int'(addr >> byteOffBits) % refWords;
    endfunction

    function automatic logic [31:0] blockAddr(input int blk, input int off);
        return 32'(blk * blockBytes + off * (wordBits / 8));
    endfunction

    function automatic logic [31:0] randomAddr();
        int blk;
        int off;
        blk = int'($urandom_range(memLines - 1));
        off = int'($urandom_range(wordsPerBlock - 1));
        return blockAddr(blk, off);
    endfunction

    // Hit 2 cycles, clean miss latency+4, dirty miss another latency+1
    function automatic int expectedCycles(input logic [31:0] addr);
        cacheAddr_u a;
        a.raw = addr;
        if (modelValid[a.f.index] && modelTag[a.f.index] == a.f.tag) begin
            return 2;
        end
        if (modelValid[a.f.index] && modelDirty[a.f.index]) begin
            return (memLatency + 4) + (memLatency + 1);
        end
        return memLatency + 4;
    endfunction

    task automatic updateCacheModel(input logic [31:0] addr, input bit isWrite);
        cacheAddr_u a;
        a.raw = addr;
        if (!(modelValid[a.f.index] && modelTag[a.f.index] == a.f.tag)) begin
            modelDirty[a.f.index] = 1'b0;
        end
        modelValid[a.f.index] = 1'b1;
        modelTag[a.f.index] = a.f.tag;
        if (isWrite) begin
            modelDirty[a.f.index] = 1'b1;
        end
    endtask

    // One request, held until dataValid, then dropped
    task automatic runAccess(input bit isWrite, input logic [31:0] addr,
                             input logic [31:0] data);
        int cycles;
        int expCycles;
        int startPulses;
        bit done;
        logic [31:0] expData;
        logic [31:0] gotData;
        if (timedOut) begin
            return;
        end
        expCycles = expectedCycles(addr);
        expData = isWrite ? '0 : refMem[wordIndex(addr)];
        startPulses = pulseCount;
        memRead = !isWrite;
        memWrite = isWrite;
        aluResult = addr;
        read2Data = isWrite ? data : '0;
        requestCount++;
        cycles = 1;
        done = 1'b0;
        while (!done && cycles < waitLimit) begin
            @(negedge clk);
            cycles++;
            done = dataValid;
        end
        memRead = 1'b0;
        memWrite = 1'b0;
        if (!done) begin
            timeoutCount++;
            timedOut = 1'b1;
            $display("timeout: no dataValid within %0d cycles for address %h", waitLimit, addr);
            return;
        end
        gotData = memoryOut;
        assert (cycles == expCycles) else begin
            errorCount++;
            $display("mismatch at %0t: address %h took %0d cycles, expected %0d",
                     $time, addr, cycles, expCycles);
        end
        assert (gotData == expData) else begin
            errorCount++;
            $display("mismatch at %0t: address %h read %h, expected %h",
                     $time, addr, gotData, expData);
        end
        if (isWrite) begin
            refMem[wordIndex(addr)] = data;
        end
        updateCacheModel(addr, isWrite);
        @(negedge clk);
        assert (pulseCount == startPulses + 1 && !stall && !dataValid) else begin
            errorCount++;
            $display("mismatch at %0t: %0d dataValid pulses for address %h",
                     $time, pulseCount - startPulses, addr);
        end
    endtask

    initial begin
        logic [31:0] addrA;
        logic [31:0] addrB;
        logic [31:0] dataA;
        logic [31:0] dataB;
        void'($urandom(seed));
        clk = 1'b0;
        rst = 1'b1;
        memRead = 1'b0;
        memWrite = 1'b0;
        aluResult = '0;
        read2Data = '0;
        errorCount = 0;
        timeoutCount = 0;
        pulseCount = 0;
        requestCount = 0;
        timedOut = 1'b0;
        for (int i = 0; i < refWords; i++) begin
            refMem[i] = '0;
        end
        modelValid = '0;
        modelDirty = '0;
        for (int i = 0; i < numSets; i++) begin
            modelTag[i] = '0;
        end

        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (!stall && !dataValid && memoryOut == '0) else begin
            errorCount++;
            $display("mismatch at %0t: outputs not idle after reset", $time);
        end

        // Never written, so memory returns zero
        runAccess(1'b0, blockAddr(4, int'($urandom_range(wordsPerBlock - 1))), '0);

        // Store misses, the loads that follow hit
        addrA = blockAddr(9, int'($urandom_range(wordsPerBlock - 1)));
        addrB = blockAddr(9, int'($urandom_range(wordsPerBlock - 1)));
        runAccess(1'b1, addrA, $urandom());
        runAccess(1'b0, addrA, '0);
        runAccess(1'b1, addrB, $urandom());
        runAccess(1'b0, addrB, '0);

        // Same set, different tag
        addrA = blockAddr(2, int'($urandom_range(wordsPerBlock - 1)));
        addrB = blockAddr(2 + numSets, int'($urandom_range(wordsPerBlock - 1)));
        dataA = $urandom();
        dataB = $urandom();
        runAccess(1'b1, addrA, dataA);
        runAccess(1'b1, addrB, dataB);
        runAccess(1'b0, addrA, '0);
        runAccess(1'b0, addrB, '0);

        for (int i = 0; i < 24; i++) begin
            runAccess(1'($urandom_range(1)), randomAddr(), $urandom());
        end

        if (!timedOut) begin
            assert (pulseCount == requestCount) else begin
                errorCount++;
                $display("mismatch at %0t: %0d pulses for %0d requests",
                         $time, pulseCount, requestCount);
            end
        end

        $display("errors: %0d mismatches, %0d timeouts", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
design/cacheAddrPkg.sv
design/blockPkg.sv
design/dataCache.sv
design/memController.sv
design/memAccessCtrl.sv
design/memStage.sv
verif/memStageTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= memStageTb
RTL_TOP ?= memStage
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS ?= --binary --timing --assert --timescale $(TIMESCALE)
LINT_FLAGS ?= --lint-only --timing --timescale $(TIMESCALE)
RTL_SRCS ?= design/cacheAddrPkg.sv design/blockPkg.sv design/dataCache.sv \
            design/memController.sv design/memAccessCtrl.sv design/memStage.sv
PASS_MSG ?= TEST PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; status=$$?; echo "$$out"; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)
